//--- muscle_pool.f
+incdir+tb
logic/pool_pkg.sv
logic/host_pkg.sv
logic/param_regs.sv
logic/drive_scaler.sv
logic/mn_pool.sv
logic/spike_counter_bank.sv
logic/muap_summer.sv
logic/muscle_pool_top.sv
tb/tb_muscle_pool.sv

//--- Bender.yml
package:
  name: muscle_pool

sources:
  # packages first, then the pool stages and the top level
  - logic/pool_pkg.sv
  - logic/host_pkg.sv
  - logic/param_regs.sv
  - logic/drive_scaler.sv
  - logic/mn_pool.sv
  - logic/spike_counter_bank.sv
  - logic/muap_summer.sv
  - logic/muscle_pool_top.sv

  # testbench with its included checks
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_muscle_pool.sv

//--- tb/tb_pool_checks.svh
`ifndef TB_POOL_CHECKS_SVH
`define TB_POOL_CHECKS_SVH

    // pulses idle right after reset
    reset_idle: assert property (@(posedge ep50trig) disable iff (reset_global)
        $fell(reset_global) |-> (o_mn_spikes == '0 && !o_count_valid && !o_total_valid))
    else begin
        $display("** Error: o_mn_spikes = 0x%h, o_count_valid = 0x%h, o_total_valid = 0x%h",
                 $sampled(o_mn_spikes), $sampled(o_count_valid), $sampled(o_total_valid));
        stop_with_failure();
    end

    // counts and total cleared by reset
    reset_clear: assert property (@(posedge ep50trig) disable iff (reset_global)
        $fell(reset_global) |-> (o_mn_counts == '0 && o_total == '0))
    else begin
        $display("** Error: after reset o_mn_counts = 0x%h, o_total = 0x%h",
                 $sampled(o_mn_counts), $sampled(o_total));
        stop_with_failure();
    end

    // loaded registers including unused trigger bits
    params_match: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_muscle_pool_top.gain == m_gain && i_muscle_pool_top.threshold == m_thresh)
    else begin
        $display("** Error: gain = 0x%h, expected 0x%h, threshold = 0x%h, expected 0x%h",
                 $sampled(i_muscle_pool_top.gain), $sampled(m_gain),
                 $sampled(i_muscle_pool_top.threshold), $sampled(m_thresh));
        stop_with_failure();
    end

    spikes_match: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_mn_spikes == m_spikes)
    else begin
        $display("** Error: o_mn_spikes = 0x%h, expected 0x%h",
                 $sampled(o_mn_spikes), $sampled(m_spikes));
        stop_with_failure();
    end

    size_order: assert property (@(posedge ep50trig) disable iff (reset_global)
        size_ordered(cum_spikes))
    else begin
        $display("a smaller motoneuron fired less often than a larger one");
        stop_with_failure();
    end

    // window closes exactly one cycle after the tick
    tick_to_valid: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_count_valid == $past(i_sim_tick) && o_count_valid == m_count_valid)
    else begin
        $display("** Error: o_count_valid = 0x%h, expected 0x%h",
                 $sampled(o_count_valid), $sampled(m_count_valid));
        stop_with_failure();
    end

    counts_match: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_count_valid |-> o_mn_counts == m_counts)
    else begin
        $display("** Error: o_mn_counts = 0x%h, expected 0x%h",
                 $sampled(o_mn_counts), $sampled(m_counts));
        stop_with_failure();
    end

    valid_to_total: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_total_valid == $past(o_count_valid) && o_total_valid == m_total_valid)
    else begin
        $display("** Error: o_total_valid = 0x%h, expected 0x%h",
                 $sampled(o_total_valid), $sampled(m_total_valid));
        stop_with_failure();
    end

    // total against the counts it came with and the model
    total_match: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_total_valid |-> (o_total == weighted_total($past(o_mn_counts)) && o_total == m_total))
    else begin
        $display("** Error: o_total = 0x%h, expected 0x%h",
                 $sampled(o_total), $sampled(m_total));
        stop_with_failure();
    end

    silent_counts: assert property (@(posedge ep50trig) disable iff (reset_global)
        quiet_window && o_count_valid |-> o_mn_counts == '0)
    else begin
        $display("** Error: o_mn_counts = 0x%h, expected 0x0 in a silent window",
                 $sampled(o_mn_counts));
        stop_with_failure();
    end

    silent_total: assert property (@(posedge ep50trig) disable iff (reset_global)
        quiet_window && o_total_valid |-> o_total == '0)
    else begin
        $display("** Error: o_total = 0x%h, expected 0x0 in a silent window", $sampled(o_total));
        stop_with_failure();
    end

`endif

//--- tb/tb_muscle_pool.sv
`default_nettype none
`timescale 1ns/1ns

module tb_muscle_pool
    import pool_pkg::*;
    import host_pkg::*;
;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;                    // ns after the rising edge
    localparam int RESET_CYCLES = 16;
    localparam int WINDOW_LEN   = 100;                  // cycles per sim tick
    localparam int NUM_WINDOWS  = 30;
    localparam int QUIET_WIN    = 20;                   // window with no presynaptic input
    // 30 windows plus ten spare ones for reset and the final total
    localparam int TIMEOUT_CYCLES = (NUM_WINDOWS + 10) * WINDOW_LEN;

    logic                          ep50trig;
    logic                          reset_global;
    logic [HALF_W-1:0]             i_wire_lo;
    logic [HALF_W-1:0]             i_wire_hi;
    logic [TRIG_W-1:0]             i_trig;
    logic                          i_spike_in;
    logic                          i_sim_tick;
    logic [NUM_MN-1:0]             o_mn_spikes;
    logic [NUM_MN-1:0][CNT_W-1:0]  o_mn_counts;
    logic                          o_count_valid;
    logic [TOT_W-1:0]              o_total;
    logic                          o_total_valid;

    integer seed = 32'h52d87e7f;                        // fixed stimulus seed
    int     cycle_count;
    int     totals_seen;                                // o_total_valid pulses so far
    int     busy_windows;                               // totals that were nonzero
    int     quiet_totals;                               // totals checked in silence
    logic   quiet_window;                               // set around the silent window
    logic [NUM_MN-1:0][31:0] cum_spikes;                // spikes per unit since reset

    // reference model state
    logic [CUR_W-1:0]              m_gain;
    logic [CUR_W-1:0]              m_thresh;
    longint unsigned               m_drive [NUM_MN];
    longint unsigned               m_mem [NUM_MN];
    logic [NUM_MN-1:0]             m_spikes;
    int unsigned                   m_run [NUM_MN];
    logic [NUM_MN-1:0][CNT_W-1:0]  m_counts;
    logic                          m_count_valid;
    logic [TOT_W-1:0]              m_total;
    logic                          m_total_valid;

    muscle_pool_top i_muscle_pool_top (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_wire_lo     (i_wire_lo),
        .i_wire_hi     (i_wire_hi),
        .i_trig        (i_trig),
        .i_spike_in    (i_spike_in),
        .i_sim_tick    (i_sim_tick),
        .o_mn_spikes   (o_mn_spikes),
        .o_mn_counts   (o_mn_counts),
        .o_count_valid (o_count_valid),
        .o_total       (o_total),
        .o_total_valid (o_total_valid)
    );

    initial ep50trig = 1'b0;
    always #(CLK_PERIOD / 2) ep50trig = ~ep50trig;

    // first failure ends the run
    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    // emg total from a set of window counts
    function automatic logic [TOT_W-1:0] weighted_total(
        input logic [NUM_MN-1:0][CNT_W-1:0] counts
    );
        logic [TOT_W-1:0] acc;
        acc = '0;
        for (int k = 0; k < NUM_MN; k++) begin
            acc = acc + counts[k] * MUAP_WEIGHT[k];
        end
        return acc;
    endfunction

    // bigger size factor means at least as many spikes so far
    function automatic bit size_ordered(input logic [NUM_MN-1:0][31:0] cum);
        for (int k = 0; k < NUM_MN - 1; k++) begin
            if (cum[k] < cum[k+1]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // cycle model of the pool, built from the timing rules
    always @(posedge ep50trig) begin : ref_model
        longint unsigned sum;
        longint unsigned th_mem;
        if (reset_global) begin
            m_gain        <= GAIN_RESET;
            m_thresh      <= THRESH_RESET;
            m_spikes      <= '0;
            m_counts      <= '0;
            m_count_valid <= 1'b0;
            m_total       <= '0;
            m_total_valid <= 1'b0;
            for (int k = 0; k < NUM_MN; k++) begin
                m_drive[k] <= 0;
                m_mem[k]   <= 0;
                m_run[k]   <= 0;
            end
        end else begin
            if (i_trig[TRIG_GAIN]) begin
                m_gain <= {i_wire_hi, i_wire_lo};
            end
            if (i_trig[TRIG_THRESH]) begin
                m_thresh <= {i_wire_hi, i_wire_lo};
            end
            th_mem = longint'(m_thresh) << TH_SHIFT;       // membrane units
            for (int k = 0; k < NUM_MN; k++) begin
                // current in sixteenths, only after an input spike
                m_drive[k] <= i_spike_in ? (longint'(m_gain) * SIZE_FACTOR[k]) >> SIZE_SHIFT : 0;
                sum = m_mem[k] + m_drive[k];
                m_spikes[k] <= (sum >= th_mem);
                m_mem[k]    <= (sum >= th_mem) ? 0 : sum;  // fire resets to rest
                if (i_sim_tick) begin
                    m_counts[k] <= CNT_W'(m_run[k] + m_spikes[k]);   // tick-cycle spike too
                    m_run[k]    <= 0;
                end else begin
                    m_run[k] <= m_run[k] + m_spikes[k];
                end
            end
            m_count_valid <= i_sim_tick;
            if (m_count_valid) begin
                m_total <= weighted_total(m_counts);
            end
            m_total_valid <= m_count_valid;
        end
    end

    // bookkeeping on the DUT outputs
    always @(posedge ep50trig) begin
        cycle_count <= cycle_count + 1;
        if (reset_global) begin
            cum_spikes <= '0;
        end else begin
            for (int k = 0; k < NUM_MN; k++) begin
                cum_spikes[k] <= cum_spikes[k] + o_mn_spikes[k];
            end
            if (o_total_valid) begin
                totals_seen  <= totals_seen + 1;
                busy_windows <= busy_windows + (o_total != 0);
                quiet_totals <= quiet_totals + quiet_window;
            end
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: only %0d of %0d totals arrived within %0d cycles",
                     totals_seen, NUM_WINDOWS, TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    // inputs for one cycle of the schedule
    task automatic drive_cycle(input int c);
        i_trig     = '0;                                // pulses last one cycle
        i_sim_tick = (c % WINDOW_LEN == WINDOW_LEN - 1);
        if (c >= QUIET_WIN * WINDOW_LEN - 5 && c < (QUIET_WIN + 1) * WINDOW_LEN) begin
            i_spike_in = 1'b0;                          // silent window, drained early
        end else begin
            i_spike_in = $random(seed) & 1;
        end
        case (c)
            250: begin
                i_wire_hi = 16'h0000;
                i_wire_lo = 16'h0002;
                i_trig[5] = 1'b1;                       // no register behind bit 5
            end
            260: i_trig[TRIG_THRESH] = 1'b1;            // threshold 2
            280: i_wire_lo = 16'h00c8;
            285: i_trig[TRIG_GAIN] = 1'b1;              // gain 200
            1230: i_wire_lo = 16'h0100;
            1232: i_trig[TRIG_THRESH] = 1'b1;           // threshold 256
            1240: begin
                i_wire_hi = 16'h0001;
                i_wire_lo = 16'h0000;
            end
            1242: i_trig[TRIG_GAIN] = 1'b1;             // gain from the upper half
            1250: begin
                i_wire_hi  = 16'hffff;
                i_wire_lo  = 16'hffff;
                i_trig[15] = 1'b1;                      // ignored again
            end
            QUIET_WIN * WINDOW_LEN + 2: quiet_window = 1'b1;
            (QUIET_WIN + 1) * WINDOW_LEN + 2: quiet_window = 1'b0;
            default: ;
        endcase
    endtask

    initial begin
        reset_global = 1'b1;
        i_wire_lo    = '0;
        i_wire_hi    = '0;
        i_trig       = '0;
        i_spike_in   = 1'b0;
        i_sim_tick   = 1'b0;
        quiet_window = 1'b0;
        cycle_count  = 0;
        totals_seen  = 0;
        busy_windows = 0;
        quiet_totals = 0;
        repeat (RESET_CYCLES) @(posedge ep50trig);
        #DRIVE_DELAY;
        reset_global = 1'b0;
        for (int c = 0; c < NUM_WINDOWS * WINDOW_LEN; c++) begin
            drive_cycle(c);
            @(posedge ep50trig);
            #DRIVE_DELAY;
        end
        i_spike_in = 1'b0;
        i_sim_tick = 1'b0;
        i_trig     = '0;
        // last window's total, timeout watches this
        while (totals_seen < NUM_WINDOWS) begin
            @(posedge ep50trig);
            #DRIVE_DELAY;
        end
        if (busy_windows > 0 && quiet_totals > 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("run incomplete: %0d nonzero totals, %0d silent totals checked",
                     busy_windows, quiet_totals);
            stop_with_failure();
        end
    end

    `include "tb_pool_checks.svh"

endmodule

`default_nettype wire

//--- logic/muscle_pool_top.sv
`default_nettype none
`timescale 1ns/1ns

module muscle_pool_top
    import pool_pkg::*;
    import host_pkg::*;
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    // host parameter load
    input  wire [HALF_W-1:0]               i_wire_lo,
    input  wire [HALF_W-1:0]               i_wire_hi,
    input  wire [TRIG_W-1:0]               i_trig,
    // stimulus
    input  wire                            i_spike_in,
    input  wire                            i_sim_tick,
    // pool outputs
    output logic [NUM_MN-1:0]              o_mn_spikes,
    output logic [NUM_MN-1:0][CNT_W-1:0]   o_mn_counts,
    output logic                           o_count_valid,
    output logic [TOT_W-1:0]               o_total,
    output logic                           o_total_valid
);

    logic [CUR_W-1:0]              gain;
    logic [CUR_W-1:0]              threshold;
    logic [NUM_MN-1:0][CUR_W-1:0]  drive;      // per-unit input current

    // gain and threshold registers
    param_regs i_param_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_lo    (i_wire_lo),
        .i_wire_hi    (i_wire_hi),
        .o_gain       (gain),
        .o_threshold  (threshold)
    );

    // spike in -> size-scaled currents, 1 cycle
    drive_scaler i_drive_scaler (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_spike_in   (i_spike_in),
        .i_gain       (gain),
        .o_drive      (drive)
    );

    // 7 integrate-and-fire units, 1 cycle
    mn_pool i_mn_pool (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_drive      (drive),
        .i_threshold  (threshold),
        .o_spikes     (o_mn_spikes)
    );

    // windowed counts per tick
    spike_counter_bank i_spike_counter_bank (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_spikes      (o_mn_spikes),
        .i_sim_tick    (i_sim_tick),
        .o_counts      (o_mn_counts),
        .o_count_valid (o_count_valid)
    );

    // weighted total, 2 cycles after the tick
    muap_summer i_muap_summer (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_counts      (o_mn_counts),
        .i_count_valid (o_count_valid),
        .o_total       (o_total),
        .o_total_valid (o_total_valid)
    );

endmodule

`default_nettype wire

//--- logic/muap_summer.sv
`default_nettype none
`timescale 1ns/1ns

module muap_summer
    import pool_pkg::*;
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire [NUM_MN-1:0][CNT_W-1:0]    i_counts,
    input  wire                            i_count_valid,
    output logic [TOT_W-1:0]               o_total,     // emg drive estimate
    output logic                           o_total_valid
);

    logic [TOT_W-1:0] weighted_sum;

    // sum of count * muap weight, big units count most
    always_comb begin
        weighted_sum = '0;
        for (int k = 0; k < NUM_MN; k++) begin
            weighted_sum = weighted_sum + TOT_W'(i_counts[k]) * TOT_W'(MUAP_WEIGHT[k]);
        end
    end

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            o_total       <= '0;
            o_total_valid <= 1'b0;
        end else begin
            if (i_count_valid) begin
                o_total <= weighted_sum;        // holds until the next window
            end
            o_total_valid <= i_count_valid;
        end
    end

endmodule

`default_nettype wire

//--- logic/spike_counter_bank.sv
`default_nettype none
`timescale 1ns/1ns

module spike_counter_bank
    import pool_pkg::*;
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire [NUM_MN-1:0]               i_spikes,
    input  wire                            i_sim_tick,  // closes the window
    output logic [NUM_MN-1:0][CNT_W-1:0]   o_counts,    // latched per window
    output logic                           o_count_valid
);

    logic [NUM_MN-1:0][CNT_W-1:0] run_cnt;     // open window
    logic [NUM_MN-1:0][CNT_W-1:0] next_cnt;

    // running count including this cycle's spike
    always_comb begin
        for (int k = 0; k < NUM_MN; k++) begin
            next_cnt[k] = run_cnt[k] + CNT_W'(i_spikes[k]);
        end
    end

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            run_cnt       <= '0;
            o_counts      <= '0;
            o_count_valid <= 1'b0;
        end else if (i_sim_tick) begin
            o_counts      <= next_cnt;          // spike on the tick edge lands here
            run_cnt       <= '0;                // fresh window
            o_count_valid <= 1'b1;
        end else begin
            run_cnt       <= next_cnt;
            o_count_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/mn_pool.sv
`default_nettype none
`timescale 1ns/1ns

module mn_pool
    import pool_pkg::*;
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire [NUM_MN-1:0][CUR_W-1:0]    i_drive,
    input  wire [CUR_W-1:0]                i_threshold, // shared by all units
    output logic [NUM_MN-1:0]              o_spikes     // one-cycle pulse per firing
);

    logic [NUM_MN-1:0][CUR_W-1:0] membrane;
    logic [NUM_MN-1:0][CUR_W:0]   mem_sum;      // extra bit, no wrap on the add
    logic [NUM_MN-1:0]            fire;
    logic [CUR_W-1:0]             th_scaled;

    // threshold in membrane units, kept at CUR_W like the register
    assign th_scaled = i_threshold << TH_SHIFT;

    // integrate this cycle's drive and compare
    always_comb begin
        for (int k = 0; k < NUM_MN; k++) begin
            mem_sum[k] = {1'b0, membrane[k]} + {1'b0, i_drive[k]};
            fire[k]    = (mem_sum[k] >= {1'b0, th_scaled});    // reach or pass
        end
    end

    // integrate-and-fire, each unit on its own
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            membrane <= '0;
            o_spikes <= '0;
        end else begin
            for (int k = 0; k < NUM_MN; k++) begin
                if (fire[k]) begin
                    membrane[k] <= '0;          // back to rest after a spike
                end else begin
                    // below threshold so the sum fits in CUR_W
                    membrane[k] <= mem_sum[k][CUR_W-1:0];
                end
            end
            o_spikes <= fire;
        end
    end

endmodule

`default_nettype wire

//--- logic/drive_scaler.sv
`default_nettype none
`timescale 1ns/1ns

module drive_scaler
    import pool_pkg::*;
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire                            i_spike_in,  // presynaptic level, sampled each cycle
    input  wire [CUR_W-1:0]                i_gain,
    output logic [NUM_MN-1:0][CUR_W-1:0]   o_drive      // one current per motoneuron
);

    logic [NUM_MN-1:0][CUR_W-1:0] scaled;

    // gain * factor / 16, product kept at CUR_W before the shift
    always_comb begin
        for (int k = 0; k < NUM_MN; k++) begin
            scaled[k] = CUR_W'(i_gain * SIZE_FACTOR[k]) >> SIZE_SHIFT;
        end
    end

    // drive only in a cycle after a presynaptic spike
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            o_drive <= '0;
        end else if (i_spike_in) begin
            o_drive <= scaled;
        end else begin
            o_drive <= '0;                      // no input, no current
        end
    end

endmodule

`default_nettype wire

//--- logic/param_regs.sv
`default_nettype none
`timescale 1ns/1ns

module param_regs
    import pool_pkg::*;
    import host_pkg::*;
(
    input  wire                ep50trig,
    input  wire                reset_global,
    input  wire [TRIG_W-1:0]   i_trig,          // one-cycle load pulses
    input  wire [HALF_W-1:0]   i_wire_lo,       // held levels
    input  wire [HALF_W-1:0]   i_wire_hi,
    output logic [CUR_W-1:0]   o_gain,
    output logic [CUR_W-1:0]   o_threshold      // unshifted
);

    param_word_u load_word;

    // glue the two halves into one word
    always_comb begin
        load_word.half.hi = i_wire_hi;
        load_word.half.lo = i_wire_lo;
    end

    // each register loads on its own trigger bit
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            o_gain      <= GAIN_RESET;
            o_threshold <= THRESH_RESET;
        end else begin
            if (i_trig[TRIG_GAIN]) begin
                o_gain <= load_word.value;      // new gain from next cycle
            end
            if (i_trig[TRIG_THRESH]) begin
                o_threshold <= load_word.value;
            end
            // other trigger bits have no register behind them
        end
    end

endmodule

`default_nettype wire

//--- logic/host_pkg.sv
`default_nettype none

package host_pkg;

    // trigger vector and load halves from the host
    localparam int TRIG_W = 16;
    localparam int HALF_W = 16;

    // trigger bit map, only two registers are kept
    localparam int TRIG_GAIN   = 3;             // synaptic gain
    localparam int TRIG_THRESH = 10;            // firing threshold

    // values after reset_global
    localparam logic [2*HALF_W-1:0] GAIN_RESET   = 32'd1;
    localparam logic [2*HALF_W-1:0] THRESH_RESET = 32'd30;   // x1024 in membrane units

    // one load word, seen either as the two host halves or as one value
    typedef union packed {
        struct packed {
            logic [HALF_W-1:0] hi;              // upper wire
            logic [HALF_W-1:0] lo;              // lower wire
        } half;
        logic [2*HALF_W-1:0] value;             // unsigned register value
    } param_word_u;

endpackage

`default_nettype wire

//--- logic/pool_pkg.sv
`default_nettype none

package pool_pkg;

    // pool size
    localparam int NUM_MN = 7;                  // motoneurons MN1..MN7

    // datapath widths
    localparam int CUR_W = 32;                  // gain, drive, membrane
    localparam int CNT_W = 16;                  // spikes per window
    localparam int TOT_W = 32;                  // weighted emg total

    // size principle, factors are in sixteenths
    localparam int SIZE_SHIFT = 4;

    // index 0 is MN1, the smallest unit, so it gets the largest drive
    localparam int unsigned SIZE_FACTOR [NUM_MN] = '{
        75,     // MN1 ~4.69x
        49,     // MN2 ~3.06x
        30,     // MN3
        17,     // MN4
        13,     // MN5
        10,     // MN6
        8       // MN7 0.5x
    };

    // muap amplitude per unit; big late-recruited units dominate the emg
    localparam int unsigned MUAP_WEIGHT [NUM_MN] = '{
        8,      // MN1 small muap
        10,
        13,
        17,
        30,
        49,
        75      // MN7 largest muap
    };

    // threshold register to membrane units
    localparam int TH_SHIFT = 10;

endpackage

`default_nettype wire
